// ==== include/bumpy_macros.svh ====
`ifndef BUMPY_MACROS_SVH
`define BUMPY_MACROS_SVH

// position is kept in 1/64 pixel units
`define FP_SCALE 64

// tile and sprite edge length in pixels
`define TILE_PX 64
`define SPRITE_PX 16

// visible screen in pixels
`define SCREEN_W 640
`define SCREEN_H 480

// tile grid covering the screen
`define BOARD_COLS 10
`define BOARD_ROWS 8

// configuration register map
`define CFG_ADDR_SPEED_X 8'd0
`define CFG_ADDR_SPEED_Y 8'd1
`define CFG_ADDR_JUMP 8'd2
`define CFG_ADDR_TELEPORT 8'd3

// tile n lives at base plus n
`define CFG_ADDR_TILE_BASE 8'd16

`endif

// ==== hw/bumpy_pkg.sv ====
package bumpy_pkg;

	// motion state driven by the controller
	typedef enum logic [3:0] {
		s_reset,
		s_idle,
		s_left,
		s_right,
		s_down,
		s_up,
		s_die
	} move_state_e;

	// one-hot edge of the sprite that touched something
	typedef logic [3:0] edge_code_t;
	localparam edge_code_t edge_none = 4'b0000;
	localparam edge_code_t edge_bottom = 4'b0001;
	localparam edge_code_t edge_right = 4'b0010;
	localparam edge_code_t edge_top = 4'b0100;
	localparam edge_code_t edge_left = 4'b1000;

	// what a tile does to the character standing on it
	typedef enum logic [1:0] {
		tile_free = 2'd0,
		tile_step = 2'd1,
		tile_teleport = 2'd2,
		tile_deadly = 2'd3
	} tile_kind_e;

	// registered report from the tile board
	typedef struct packed {
		logic step;
		logic free;
		logic teleport;
		logic deadly;
		logic border;
		edge_code_t hit_edge;
	} collision_t;

	// direction keys as pressed
	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
	} keys_t;

	// column in the upper nibble and row in the lower nibble
	typedef struct packed {
		logic [3:0] col;
		logic [3:0] row;
	} tile_coord_t;

	// teleport target byte as written or as a tile coordinate
	typedef union packed {
		logic [7:0] raw;
		tile_coord_t coord;
	} teleport_word_u;

	// run-time motion parameters
	typedef struct packed {
		logic [15:0] speed_x;
		logic [15:0] speed_y;
		logic [15:0] jump_height;
		teleport_word_u teleport;
	} move_cfg_t;

endpackage

// ==== hw/move_config.sv ====
`timescale 1ns/1ps
`include "bumpy_macros.svh"

module move_config (
	input	logic				clk,
	input	logic				resetN,
	input	logic				cfg_we,
	input	logic	[7:0]		cfg_addr,
	input	logic	[15:0]		cfg_wdata,
	output	bumpy_pkg::move_cfg_t	cfg,
	output	logic				tile_we,
	output	logic	[6:0]		tile_index,
	output	bumpy_pkg::tile_kind_e	tile_kind
);

	// default speeds in 1/64 pixel per frame
	localparam int SPEED_X_RESET = 120;
	localparam int SPEED_Y_RESET = 150;
	// jump apex stops 9 pixels short of one tile height
	localparam int JUMP_RESET = (`TILE_PX - 9) * `FP_SCALE;
	localparam int TILE_COUNT = `BOARD_COLS * `BOARD_ROWS;

	logic	[7:0]	tile_offset;
	logic			tile_range;

	// tile writes go straight to the board in the same cycle
	assign tile_offset = cfg_addr - `CFG_ADDR_TILE_BASE;
	assign tile_range = (cfg_addr >= `CFG_ADDR_TILE_BASE) && (tile_offset < 8'(TILE_COUNT));
	assign tile_we = cfg_we && tile_range;
	assign tile_index = tile_offset[6:0];
	// only the two low data bits carry the kind
	assign tile_kind = bumpy_pkg::tile_kind_e'(cfg_wdata[1:0]);

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			cfg.speed_x <= 16'(SPEED_X_RESET);
			cfg.speed_y <= 16'(SPEED_Y_RESET);
			cfg.jump_height <= 16'(JUMP_RESET);
			// teleport lands on tile (1,1) by default
			cfg.teleport.coord.col <= 4'd1;
			cfg.teleport.coord.row <= 4'd1;
		end else if (cfg_we) begin
			case (cfg_addr)
				`CFG_ADDR_SPEED_X: cfg.speed_x <= cfg_wdata;
				`CFG_ADDR_SPEED_Y: cfg.speed_y <= cfg_wdata;
				`CFG_ADDR_JUMP: cfg.jump_height <= cfg_wdata;
				// low byte only
				`CFG_ADDR_TELEPORT: cfg.teleport.raw <= cfg_wdata[7:0];
				default: ;
			endcase
		end
	end

endmodule

// ==== hw/bumpy_controller.sv ====
`timescale 1ns/1ps

module bumpy_controller (
	input	logic					clk,
	input	logic					resetN,
	input	bumpy_pkg::keys_t		keys,
	input	bumpy_pkg::collision_t	coll,
	output	bumpy_pkg::move_state_e	state
);

	bumpy_pkg::move_state_e	state_next;
	bumpy_pkg::move_state_e	key_state;

	// key priority is left, right, up, down
	always_comb begin
		if (keys.left) begin
			key_state = bumpy_pkg::s_left;
		end else if (keys.right) begin
			key_state = bumpy_pkg::s_right;
		end else if (keys.up) begin
			key_state = bumpy_pkg::s_up;
		end else if (keys.down) begin
			key_state = bumpy_pkg::s_down;
		end else begin
			// nothing pressed
			key_state = bumpy_pkg::s_idle;
		end
	end

	// next state
	always_comb begin
		state_next = state;
		case (state)
			// reset lasts exactly one cycle
			bumpy_pkg::s_reset: begin
				state_next = bumpy_pkg::s_idle;
			end
			// die is sticky until reset
			bumpy_pkg::s_die: begin
				state_next = bumpy_pkg::s_die;
			end
			bumpy_pkg::s_idle,
			bumpy_pkg::s_left,
			bumpy_pkg::s_right,
			bumpy_pkg::s_up,
			bumpy_pkg::s_down: begin
				// deadly tile beats any key
				if (coll.deadly) begin
					state_next = bumpy_pkg::s_die;
				end else begin
					// step and free tiles leave the choice to the keys
					state_next = key_state;
				end
			end
			default: begin
				// unused encodings recover through idle
				state_next = bumpy_pkg::s_idle;
			end
		endcase
	end

	// state register
	// the collision report is one cycle behind the position
	// so the state lands two cycles after the frame pulse
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= bumpy_pkg::s_reset;
		end else begin
			state <= state_next;
		end
	end

endmodule

// ==== hw/bumpy_move.sv ====
`timescale 1ns/1ps
`include "bumpy_macros.svh"

module bumpy_move (
	input	logic					clk,
	input	logic					resetN,
	input	logic					start_of_frame,
	input	bumpy_pkg::move_state_e	state,
	input	bumpy_pkg::collision_t	coll,
	input	bumpy_pkg::move_cfg_t	cfg,
	output	logic signed	[10:0]	offset_x,
	output	logic signed	[10:0]	offset_y,
	output	logic					dead_led
);

	// all lengths below are in 1/64 pixel
	localparam int FP = `FP_SCALE;
	localparam int TILE_FP = `TILE_PX * `FP_SCALE;
	localparam int SPRITE_FP = `SPRITE_PX * `FP_SCALE;
	// top-left corner that centers the sprite in a tile
	localparam int CENTER_FP = TILE_FP / 2 - SPRITE_FP / 2;
	// origin shift that parks the character at a border
	localparam int BORDER_SHIFT = TILE_FP + SPRITE_FP / 2;

	logic signed	[31:0]	pos_x;
	logic signed	[31:0]	pos_y;
	logic signed	[31:0]	vel_x;
	logic signed	[31:0]	vel_y;
	logic signed	[31:0]	jump_x;
	logic signed	[31:0]	jump_y;
	logic signed	[31:0]	cfg_spd_x;
	logic signed	[31:0]	cfg_spd_y;
	logic signed	[31:0]	cfg_jump;
	logic signed	[31:0]	tp_x;
	logic signed	[31:0]	tp_y;
	logic signed	[31:0]	pix_x;
	logic signed	[31:0]	pix_y;
	logic					on_bottom;
	logic					step_hit;
	logic					tp_hit;
	logic					launch;

	// config fields are unsigned magnitudes
	assign cfg_spd_x = {16'd0, cfg.speed_x};
	assign cfg_spd_y = {16'd0, cfg.speed_y};
	assign cfg_jump = {16'd0, cfg.jump_height};

	assign on_bottom = (coll.hit_edge == bumpy_pkg::edge_bottom);
	assign step_hit = coll.step && on_bottom;
	assign tp_hit = coll.teleport && on_bottom;
	// a step only launches while not already rising
	assign launch = step_hit && (vel_y >= 0);

	// center of the target tile from the coordinate view
	assign tp_x = {28'd0, cfg.teleport.coord.col} * TILE_FP + CENTER_FP;
	assign tp_y = {28'd0, cfg.teleport.coord.row} * TILE_FP + CENTER_FP;

	// jump origin
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			jump_x <= CENTER_FP;
			jump_y <= CENTER_FP;
		end else if (launch) begin
			jump_x <= pos_x;
			jump_y <= pos_y;
		end else if (coll.border) begin
			// move the origin past the limit so travel into the border stops
			if (coll.hit_edge == bumpy_pkg::edge_left) begin
				jump_x <= pos_x + BORDER_SHIFT;
			end else if (coll.hit_edge == bumpy_pkg::edge_right) begin
				jump_x <= pos_x - BORDER_SHIFT;
			end
		end
	end

	// vertical speed and the dead indicator
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			vel_y <= '0;
			dead_led <= 1'b0;
		end else begin
			case (state)
				bumpy_pkg::s_idle, bumpy_pkg::s_left, bumpy_pkg::s_right: begin
					if (launch) begin
						vel_y <= -cfg_spd_y;
					end else if ((pos_y < jump_y - cfg_jump) && (vel_y <= 0)) begin
						// apex reached, fall back
						vel_y <= cfg_spd_y;
					end
				end
				bumpy_pkg::s_up: begin
					vel_y <= -cfg_spd_y;
				end
				bumpy_pkg::s_down: begin
					vel_y <= cfg_spd_y;
					dead_led <= 1'b0;
				end
				bumpy_pkg::s_die: begin
					// frozen in place
					vel_y <= '0;
					dead_led <= 1'b1;
				end
				default: begin
					vel_y <= '0;
				end
			endcase
		end
	end

	// horizontal speed, limited to one tile from the origin
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			vel_x <= '0;
		end else begin
			case (state)
				bumpy_pkg::s_left: begin
					if ((pos_x < jump_x - TILE_FP) && (vel_x <= 0)) begin
						vel_x <= '0;
					end else begin
						vel_x <= -cfg_spd_x;
					end
				end
				bumpy_pkg::s_right: begin
					if ((pos_x > jump_x + TILE_FP) && (vel_x >= 0)) begin
						vel_x <= '0;
					end else begin
						vel_x <= cfg_spd_x;
					end
				end
				default: begin
					vel_x <= '0;
				end
			endcase
		end
	end

	// position, stepped once per frame
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pos_x <= CENTER_FP;
			pos_y <= CENTER_FP;
		end else if (tp_hit) begin
			// teleport wins and the frame step is dropped
			pos_x <= tp_x;
			pos_y <= tp_y;
		end else if (start_of_frame) begin
			pos_x <= pos_x + vel_x;
			pos_y <= pos_y + vel_y;
		end
	end

	// whole pixels
	assign pix_x = pos_x / FP;
	assign pix_y = pos_y / FP;
	assign offset_x = pix_x[10:0];
	assign offset_y = pix_y[10:0];

endmodule

// ==== hw/tile_board.sv ====
`timescale 1ns/1ps
`include "bumpy_macros.svh"

module tile_board (
	input	logic					clk,
	input	logic					resetN,
	input	logic					tile_we,
	input	logic	[6:0]			tile_index,
	input	bumpy_pkg::tile_kind_e	tile_kind,
	input	logic signed	[10:0]	offset_x,
	input	logic signed	[10:0]	offset_y,
	output	bumpy_pkg::collision_t	coll
);

	localparam int TILE_COUNT = `BOARD_COLS * `BOARD_ROWS;
	localparam int BOARD_W = `BOARD_COLS * `TILE_PX;
	localparam int BOARD_H = `BOARD_ROWS * `TILE_PX;
	localparam int HALF_SPRITE = `SPRITE_PX / 2;

	bumpy_pkg::tile_kind_e	map [TILE_COUNT];
	logic signed	[11:0]	foot_x;
	logic signed	[11:0]	foot_y;
	logic signed	[11:0]	right_x;
	logic					on_tile;
	logic	[3:0]			foot_col;
	logic	[2:0]			foot_row;
	logic	[6:0]			foot_index;
	bumpy_pkg::tile_kind_e	foot_kind;
	logic					at_left;
	logic					at_right;
	bumpy_pkg::collision_t	coll_next;

	// tile map, row-major, cleared to free
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			for (int i = 0; i < TILE_COUNT; i++) begin
				map[i] <= bumpy_pkg::tile_free;
			end
		end else if (tile_we) begin
			map[tile_index] <= tile_kind;
		end
	end

	// bottom-center pixel of the sprite
	assign foot_x = {offset_x[10], offset_x} + 12'(HALF_SPRITE);
	assign foot_y = {offset_y[10], offset_y} + 12'(`SPRITE_PX - 1);

	// footprint must sit on the board and on the visible screen
	assign on_tile = (foot_x >= 0) && (foot_x < BOARD_W) &&
		(foot_y >= 0) && (foot_y < BOARD_H) && (foot_y < `SCREEN_H);

	assign foot_col = 4'(foot_x / `TILE_PX);
	assign foot_row = 3'(foot_y / `TILE_PX);
	assign foot_index = 7'(foot_row) * 7'(`BOARD_COLS) + 7'(foot_col);
	// off the board reads as free
	assign foot_kind = on_tile ? map[foot_index] : bumpy_pkg::tile_free;

	// screen side borders
	assign right_x = {offset_x[10], offset_x} + 12'(`SPRITE_PX);
	assign at_left = (offset_x <= 0);
	assign at_right = (right_x >= `SCREEN_W);

	always_comb begin
		coll_next = '0;
		if (on_tile) begin
			coll_next.hit_edge = bumpy_pkg::edge_bottom;
			// exactly one kind flag per tile
			case (foot_kind)
				bumpy_pkg::tile_free: coll_next.free = 1'b1;
				bumpy_pkg::tile_step: coll_next.step = 1'b1;
				bumpy_pkg::tile_teleport: coll_next.teleport = 1'b1;
				bumpy_pkg::tile_deadly: coll_next.deadly = 1'b1;
				default: coll_next.free = 1'b1;
			endcase
		end
		// border overrides the edge code
		if (at_left || at_right) begin
			coll_next.border = 1'b1;
			coll_next.hit_edge = at_left ? bumpy_pkg::edge_left : bumpy_pkg::edge_right;
		end
	end

	// one cycle behind the position
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			coll <= '0;
		end else begin
			coll <= coll_next;
		end
	end

endmodule

// ==== hw/bumpy_game_top.sv ====
`timescale 1ns/1ps

module bumpy_game_top (
	input	logic					clk,
	input	logic					resetN,
	input	logic					start_of_frame,
	input	bumpy_pkg::keys_t		keys,
	input	logic					cfg_we,
	input	logic	[7:0]			cfg_addr,
	input	logic	[15:0]			cfg_wdata,
	output	logic signed	[10:0]	offset_x,
	output	logic signed	[10:0]	offset_y,
	output	bumpy_pkg::move_state_e	state,
	output	logic					dead_led
);

	bumpy_pkg::move_cfg_t	cfg;
	bumpy_pkg::collision_t	coll;
	bumpy_pkg::tile_kind_e	tile_kind;
	logic					tile_we;
	logic	[6:0]			tile_index;

	// run-time registers and tile writes
	move_config move_config_inst (
		.clk		(clk),
		.resetN		(resetN),
		.cfg_we		(cfg_we),
		.cfg_addr	(cfg_addr),
		.cfg_wdata	(cfg_wdata),
		.cfg		(cfg),
		.tile_we	(tile_we),
		.tile_index	(tile_index),
		.tile_kind	(tile_kind)
	);

	// keys and collisions to motion state
	bumpy_controller bumpy_controller_inst (
		.clk	(clk),
		.resetN	(resetN),
		.keys	(keys),
		.coll	(coll),
		.state	(state)
	);

	// position integrator
	bumpy_move bumpy_move_inst (
		.clk			(clk),
		.resetN			(resetN),
		.start_of_frame	(start_of_frame),
		.state			(state),
		.coll			(coll),
		.cfg			(cfg),
		.offset_x		(offset_x),
		.offset_y		(offset_y),
		.dead_led		(dead_led)
	);

	// tile under the character and border hits
	tile_board tile_board_inst (
		.clk		(clk),
		.resetN		(resetN),
		.tile_we	(tile_we),
		.tile_index	(tile_index),
		.tile_kind	(tile_kind),
		.offset_x	(offset_x),
		.offset_y	(offset_y),
		.coll		(coll)
	);

endmodule

// ==== bench/bumpy_tb.sv ====
`timescale 1ns/1ps
`include "bumpy_macros.svh"

module bumpy_tb;

	// frames per test feed the watchdog budget
	localparam int FRAMES_RIGHT = 40;
	localparam int FRAMES_RIGHT_RND = 30;
	localparam int FRAMES_JUMP = 30;
	localparam int FRAMES_TELEPORT = 3;
	localparam int FRAMES_DEADLY = 30;
	localparam int FRAMES_STRESS = 40;
	localparam int TOTAL_FRAMES = FRAMES_RIGHT + FRAMES_RIGHT_RND + FRAMES_JUMP +
		FRAMES_TELEPORT + FRAMES_DEADLY + FRAMES_STRESS;
	localparam int FRAME_CYCLES = 10;
	localparam int MARGIN_CYCLES = 600;
	// model lengths in 1/64 pixel
	localparam int TILE_FP = `TILE_PX * `FP_SCALE;
	localparam int SPRITE_FP = `SPRITE_PX * `FP_SCALE;
	localparam int CENTER_FP = (TILE_FP - SPRITE_FP) / 2;

	typedef struct packed {
		logic signed [31:0] x;
		logic signed [31:0] y;
	} pos_t;

	logic clk;
	logic resetN;
	logic start_of_frame;
	bumpy_pkg::keys_t keys;
	logic cfg_we;
	logic [7:0] cfg_addr;
	logic [15:0] cfg_wdata;
	logic signed [10:0] offset_x;
	logic signed [10:0] offset_y;
	bumpy_pkg::move_state_e state;
	logic dead_led;

	// reference model state
	pos_t m_pos;
	int m_vx, m_vy, m_jx, m_jy;
	bumpy_pkg::move_state_e m_state;
	logic m_led;
	bumpy_pkg::collision_t m_coll;
	bumpy_pkg::move_cfg_t m_cfg;
	bumpy_pkg::keys_t m_keys;
	bumpy_pkg::tile_kind_e m_map [`BOARD_COLS * `BOARD_ROWS];

	int seed;
	int error_count, check_count, tests_run, tests_failed;
	event sample_ev;

	initial clk = 1'b0;
	always #10 clk = ~clk;

	bumpy_game_top bumpy_game_top_inst (
		.clk			(clk),
		.resetN			(resetN),
		.start_of_frame	(start_of_frame),
		.keys			(keys),
		.cfg_we			(cfg_we),
		.cfg_addr		(cfg_addr),
		.cfg_wdata		(cfg_wdata),
		.offset_x		(offset_x),
		.offset_y		(offset_y),
		.state			(state),
		.dead_led		(dead_led)
	);

	task automatic check_offsets(input logic signed [10:0] got_x, got_y, exp_x, exp_y);
		check_count++;
		if (got_x !== exp_x || got_y !== exp_y) begin
			error_count++;
			$display("[ERROR] %0t: offset (%0d,%0d), expected (%0d,%0d)", $time,
				got_x, got_y, exp_x, exp_y);
		end
	endtask

	task automatic expect_state(input bumpy_pkg::move_state_e got, exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t: state %0d, expected %0d", $time, got, exp);
		end
	endtask

	task automatic verify_led(input logic got, exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t: dead_led %b, expected %b", $time, got, exp);
		end
	endtask

	// key priority is left then right then up then down
	function automatic bumpy_pkg::move_state_e key_choice(input bumpy_pkg::keys_t k);
		if (k.left) return bumpy_pkg::s_left;
		if (k.right) return bumpy_pkg::s_right;
		if (k.up) return bumpy_pkg::s_up;
		if (k.down) return bumpy_pkg::s_down;
		return bumpy_pkg::s_idle;
	endfunction

	// tile under the bottom-center pixel
	// border flags win the edge code
	function automatic bumpy_pkg::collision_t probe_tile(input pos_t p);
		bumpy_pkg::collision_t c;
		int px, py, fx, fy;
		px = p.x / `FP_SCALE;
		py = p.y / `FP_SCALE;
		fx = px + `SPRITE_PX / 2;
		fy = py + `SPRITE_PX - 1;
		c = '0;
		if (fx >= 0 && fx < `BOARD_COLS * `TILE_PX && fy >= 0 &&
			fy < `BOARD_ROWS * `TILE_PX && fy < `SCREEN_H) begin
			c.hit_edge = bumpy_pkg::edge_bottom;
			case (m_map[(fy / `TILE_PX) * `BOARD_COLS + fx / `TILE_PX])
				bumpy_pkg::tile_step: c.step = 1'b1;
				bumpy_pkg::tile_teleport: c.teleport = 1'b1;
				bumpy_pkg::tile_deadly: c.deadly = 1'b1;
				default: c.free = 1'b1;
			endcase
		end
		if (px <= 0 || px + `SPRITE_PX >= `SCREEN_W) begin
			c.border = 1'b1;
			c.hit_edge = (px <= 0) ? bumpy_pkg::edge_left : bumpy_pkg::edge_right;
		end
		return c;
	endfunction

	// teleport on the bottom edge beats the frame step
	function automatic pos_t next_position(input pos_t p, input logic sof,
		input bumpy_pkg::collision_t c, input bumpy_pkg::move_cfg_t cfg, input int vx, vy);
		pos_t n;
		n = p;
		if (c.teleport && c.hit_edge == bumpy_pkg::edge_bottom) begin
			n.x = int'(cfg.teleport.coord.col) * TILE_FP + CENTER_FP;
			n.y = int'(cfg.teleport.coord.row) * TILE_FP + CENTER_FP;
		end else if (sof) begin
			n.x = p.x + vx;
			n.y = p.y + vy;
		end
		return n;
	endfunction

	// one clock of the motion rules
	// every term comes from the previous clock
	function automatic void advance_cycle(input logic sof);
		bumpy_pkg::collision_t c_next;
		bumpy_pkg::move_state_e s_next;
		pos_t p_next;
		logic launch;
		logic led_n;
		int sx, sy, jh, vx_n, vy_n, jx_n, jy_n;
		sx = int'(m_cfg.speed_x);
		sy = int'(m_cfg.speed_y);
		jh = int'(m_cfg.jump_height);
		c_next = probe_tile(m_pos);
		p_next = next_position(m_pos, sof, m_coll, m_cfg, m_vx, m_vy);
		launch = m_coll.step && (m_coll.hit_edge == bumpy_pkg::edge_bottom) && (m_vy >= 0);
		// die is sticky and deadly beats keys
		if (m_state == bumpy_pkg::s_die || m_coll.deadly) s_next = bumpy_pkg::s_die;
		else s_next = key_choice(m_keys);
		// jump origin follows launches and is pushed away at a border
		jx_n = m_jx;
		jy_n = m_jy;
		if (launch) begin
			jx_n = m_pos.x;
			jy_n = m_pos.y;
		end else if (m_coll.border && m_coll.hit_edge == bumpy_pkg::edge_left) begin
			jx_n = m_pos.x + TILE_FP + SPRITE_FP / 2;
		end else if (m_coll.border && m_coll.hit_edge == bumpy_pkg::edge_right) begin
			jx_n = m_pos.x - TILE_FP - SPRITE_FP / 2;
		end
		vy_n = m_vy;
		led_n = m_led;
		case (m_state)
			bumpy_pkg::s_idle, bumpy_pkg::s_left, bumpy_pkg::s_right: begin
				if (launch) vy_n = -sy;
				else if (m_pos.y < m_jy - jh && m_vy <= 0) vy_n = sy;
			end
			bumpy_pkg::s_up: vy_n = -sy;
			bumpy_pkg::s_down: begin
				vy_n = sy;
				led_n = 1'b0;
			end
			bumpy_pkg::s_die: begin
				vy_n = 0;
				led_n = 1'b1;
			end
			default: vy_n = 0;
		endcase
		// sideways travel ends one tile from the origin
		case (m_state)
			bumpy_pkg::s_left: vx_n = (m_pos.x < m_jx - TILE_FP && m_vx <= 0) ? 0 : -sx;
			bumpy_pkg::s_right: vx_n = (m_pos.x > m_jx + TILE_FP && m_vx >= 0) ? 0 : sx;
			default: vx_n = 0;
		endcase
		m_pos = p_next;
		m_coll = c_next;
		m_state = s_next;
		m_vx = vx_n;
		m_vy = vy_n;
		m_jx = jx_n;
		m_jy = jy_n;
		m_led = led_n;
	endfunction

	function automatic void reset_model();
		m_pos.x = CENTER_FP;
		m_pos.y = CENTER_FP;
		m_vx = 0;
		m_vy = 0;
		m_jx = CENTER_FP;
		m_jy = CENTER_FP;
		m_state = bumpy_pkg::s_idle;
		m_led = 1'b0;
		m_keys = '0;
		// default speeds and teleport target (1,1)
		// jump apex sits 9 pixels short of a tile
		m_cfg.speed_x = 16'd120;
		m_cfg.speed_y = 16'd150;
		m_cfg.jump_height = 16'd3520;
		m_cfg.teleport.raw = 8'h11;
		foreach (m_map[i]) m_map[i] = bumpy_pkg::tile_free;
		m_coll = probe_tile(m_pos);
	endfunction

	task automatic apply_reset();
		@(posedge clk);
		resetN <= 1'b0;
		start_of_frame <= 1'b0;
		keys <= '0;
		cfg_we <= 1'b0;
		repeat (2) @(posedge clk);
		resetN <= 1'b1;
		repeat (3) @(posedge clk);
		reset_model();
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			advance_cycle(1'b0);
		end
	endtask

	// single-cycle register write
	// tile effects settle over the idle cycles
	task automatic write_reg(input logic [7:0] addr, input logic [15:0] data);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we <= 1'b0;
		case (addr)
			`CFG_ADDR_SPEED_X: m_cfg.speed_x = data;
			`CFG_ADDR_SPEED_Y: m_cfg.speed_y = data;
			`CFG_ADDR_JUMP: m_cfg.jump_height = data;
			`CFG_ADDR_TELEPORT: m_cfg.teleport.raw = data[7:0];
			default: begin
				if (addr >= `CFG_ADDR_TILE_BASE && addr < `CFG_ADDR_TILE_BASE + 80)
					m_map[addr - `CFG_ADDR_TILE_BASE] = bumpy_pkg::tile_kind_e'(data[1:0]);
			end
		endcase
		idle_cycles(12);
	endtask

	// keys change with the pulse
	// outputs are sampled 6 cycles later
	task automatic run_frame(input bumpy_pkg::keys_t k);
		@(posedge clk);
		start_of_frame <= 1'b1;
		keys <= k;
		advance_cycle(1'b1);
		m_keys = k;
		@(posedge clk);
		start_of_frame <= 1'b0;
		repeat (5) @(posedge clk);
		repeat (FRAME_CYCLES - 1) advance_cycle(1'b0);
		@(negedge clk);
		-> sample_ev;
		repeat (3) @(posedge clk);
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (error_count == start_errors) begin
			$display("test %-12s PASS", name);
		end else begin
			tests_failed++;
			$display("test %-12s FAIL with %0d mismatches", name, error_count - start_errors);
		end
	endtask

	// compare DUT against the model at each sample point
	always @(sample_ev) begin
		check_offsets(offset_x, offset_y, 11'(m_pos.x / `FP_SCALE), 11'(m_pos.y / `FP_SCALE));
		expect_state(state, m_state);
		verify_led(dead_led, m_led);
	end

	initial begin
		repeat (TOTAL_FRAMES * FRAME_CYCLES + MARGIN_CYCLES) @(posedge clk);
		$display("timeout: run did not finish in the cycle budget");
		$display("Verification failed");
		$finish;
	end

	initial begin
		int start_errors;
		bumpy_pkg::keys_t k;
		seed = 32'h6d63_0a3c;
		resetN = 1'b0;
		start_of_frame = 1'b0;
		keys = '0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		tests_failed = 0;
		reset_model();

		// character sits centered in tile (0,0)
		start_errors = error_count;
		apply_reset();
		@(negedge clk);
		check_offsets(offset_x, offset_y, 11'sd24, 11'sd24);
		expect_state(state, bumpy_pkg::s_idle);
		verify_led(dead_led, 1'b0);
		report_test("reset", start_errors);

		// right held with default and random speed
		start_errors = error_count;
		apply_reset();
		k = '0;
		k.right = 1'b1;
		repeat (FRAMES_RIGHT) run_frame(k);
		apply_reset();
		write_reg(`CFG_ADDR_SPEED_X, 16'(64 + $unsigned($random(seed)) % 320));
		repeat (FRAMES_RIGHT_RND) run_frame(k);
		report_test("horizontal", start_errors);

		// step tile under the feet
		start_errors = error_count;
		apply_reset();
		write_reg(`CFG_ADDR_TILE_BASE, 16'(bumpy_pkg::tile_step));
		repeat (FRAMES_JUMP) run_frame('0);
		report_test("jump", start_errors);

		// target column 3 row 2
		start_errors = error_count;
		apply_reset();
		write_reg(`CFG_ADDR_TELEPORT, 16'h0032);
		write_reg(`CFG_ADDR_TILE_BASE, 16'(bumpy_pkg::tile_teleport));
		repeat (FRAMES_TELEPORT) run_frame('0);
		@(negedge clk);
		check_offsets(offset_x, offset_y, 11'sd216, 11'sd152);
		report_test("teleport", start_errors);

		// right runs into the deadly tile at index 1
		// random keys afterwards must not leave die
		start_errors = error_count;
		apply_reset();
		write_reg(`CFG_ADDR_TILE_BASE + 8'd1, 16'(bumpy_pkg::tile_deadly));
		repeat (FRAMES_DEADLY - 10) run_frame(k);
		repeat (10) run_frame(bumpy_pkg::keys_t'(4'($random(seed))));
		@(negedge clk);
		expect_state(state, bumpy_pkg::s_die);
		verify_led(dead_led, 1'b1);
		report_test("deadly", start_errors);

		// random keys with random speeds on a free board
		start_errors = error_count;
		apply_reset();
		write_reg(`CFG_ADDR_SPEED_X, 16'(64 + $unsigned($random(seed)) % 192));
		write_reg(`CFG_ADDR_SPEED_Y, 16'(64 + $unsigned($random(seed)) % 192));
		repeat (FRAMES_STRESS) run_frame(bumpy_pkg::keys_t'(4'($random(seed))));
		report_test("stress", start_errors);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0 && tests_failed == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
hw/bumpy_pkg.sv
hw/move_config.sv
hw/bumpy_controller.sv
hw/bumpy_move.sv
hw/tile_board.sv
hw/bumpy_game_top.sv
bench/bumpy_tb.sv
